// ==== common/sa_pkg.sv ====
// shared types, sizes and encodings for the attention engine, referenced as sa_pkg::name
package sa_pkg;

    // feature dimension, also the lane count of both dot-product units
    localparam int dim = 8;

    // three weight matrices of 64 elements each
    localparam int load_cycles = 192;

    // input and weight element
    typedef logic signed [7:0] elem_t;

    // one Q, K or V entry
    typedef logic signed [18:0] proj_t;

    // one A entry, also the sign-extended Q operand of the score pass
    typedef logic signed [39:0] attn_t;

    // raw sum of the wide unit
    typedef logic signed [61:0] wide_t;

    // streamed result value
    typedef logic signed [63:0] out_t;

    // row or column index
    typedef logic [2:0] idx_t;

    // row count, holds T
    typedef logic [3:0] rows_t;

    typedef enum logic [2:0] {
        ph_idle,
        ph_load,
        ph_proj,
        ph_score,
        ph_out
    } phase_t;

    typedef enum logic [1:0] {
        mat_q,
        mat_k,
        mat_v
    } mat_t;

endpackage

// ==== verilog/sa_dot_product.sv ====
// eight-lane signed dot product with a registered sum, typed per payload by the instantiating level
`timescale 1ns/1ps

module sa_dot_product #(
    parameter type a_t   = sa_pkg::elem_t,
    parameter type b_t   = sa_pkg::elem_t,
    parameter type sum_t = sa_pkg::proj_t
) (
    input  logic clk,
    input  logic rst_n,
    input  logic in_strobe,
    input  a_t   a_vec [sa_pkg::dim],
    input  b_t   b_vec [sa_pkg::dim],
    output logic out_strobe,
    output sum_t sum
);

    sum_t prod [sa_pkg::dim];
    sum_t pair [sa_pkg::dim / 2];
    sum_t quad [2];

    // operands widened to the sum type before multiplying
    always_comb begin
        for (int i = 0; i < sa_pkg::dim; i++) begin
            prod[i] = sum_t'(a_vec[i]) * sum_t'(b_vec[i]);
        end
        for (int i = 0; i < sa_pkg::dim / 2; i++) begin
            pair[i] = prod[2 * i] + prod[2 * i + 1];
        end
        quad[0] = pair[0] + pair[1];
        quad[1] = pair[2] + pair[3];
    end

    always_ff @(posedge clk) begin
        if (in_strobe) begin
            sum <= quad[0] + quad[1];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_strobe <= 1'b0;
        end else begin
            out_strobe <= in_strobe;
        end
    end

    strobe_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(in_strobe));

endmodule

// ==== verilog/sa_sequencer.sv ====
// phase sequencer, tracks the load stream and issues one dot-product item per cycle afterwards
`timescale 1ns/1ps

module sa_sequencer (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_valid,
    input  logic [3:0]      t_rows,
    output sa_pkg::phase_t  phase,
    output sa_pkg::rows_t   rows,
    output sa_pkg::idx_t    load_row,
    output sa_pkg::idx_t    load_col,
    output sa_pkg::idx_t    row,
    output sa_pkg::idx_t    col,
    output sa_pkg::mat_t    mat_sel,
    output logic            issue,
    output logic            wr_en,
    output sa_pkg::idx_t    wr_row,
    output sa_pkg::idx_t    wr_col,
    output sa_pkg::mat_t    wr_mat
);

    logic [7:0]   load_cnt;
    sa_pkg::mat_t mat_cur;
    logic         row_last;
    logic         col_last;

    // load cycle k maps to matrix k/64, row (k mod 64)/8, column k mod 8
    assign load_row = load_cnt[5:3];
    assign load_col = load_cnt[2:0];
    assign mat_sel  = (phase == sa_pkg::ph_proj) ? mat_cur : sa_pkg::mat_t'(load_cnt[7:6]);

    assign issue = (phase == sa_pkg::ph_proj) || (phase == sa_pkg::ph_score) ||
                   (phase == sa_pkg::ph_out);

    // score walks a T x T space, proj and out walk T x 8
    assign row_last = ({1'b0, row} == rows - 4'd1);
    assign col_last = (phase == sa_pkg::ph_score) ? ({1'b0, col} == rows - 4'd1) :
                      (col == 3'd7);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase    <= sa_pkg::ph_idle;
            rows     <= 4'd8;
            load_cnt <= '0;
            row      <= '0;
            col      <= '0;
            mat_cur  <= sa_pkg::mat_q;
        end else begin
            case (phase)
                sa_pkg::ph_idle: begin
                    if (in_valid) begin
                        phase    <= sa_pkg::ph_load;
                        load_cnt <= 8'd1;
                        case (t_rows)
                            4'd1:    rows <= 4'd1;
                            4'd4:    rows <= 4'd4;
                            default: rows <= 4'd8;
                        endcase
                    end
                end
                sa_pkg::ph_load: begin
                    if (in_valid) begin
                        if (load_cnt == 8'(sa_pkg::load_cycles - 1)) begin
                            phase    <= sa_pkg::ph_proj;
                            load_cnt <= '0;
                        end else begin
                            load_cnt <= load_cnt + 8'd1;
                        end
                    end
                end
                default: begin
                    if (!col_last) begin
                        col <= col + 3'd1;
                    end else begin
                        col <= '0;
                        if (!row_last) begin
                            row <= row + 3'd1;
                        end else begin
                            row <= '0;
                            // Q, K and V share the proj phase
                            if (phase == sa_pkg::ph_proj && mat_cur != sa_pkg::mat_v) begin
                                mat_cur <= sa_pkg::mat_t'(mat_cur + 2'd1);
                            end else begin
                                mat_cur <= sa_pkg::mat_q;
                                case (phase)
                                    sa_pkg::ph_proj:  phase <= sa_pkg::ph_score;
                                    sa_pkg::ph_score: phase <= sa_pkg::ph_out;
                                    default:          phase <= sa_pkg::ph_idle;
                                endcase
                            end
                        end
                    end
                end
            endcase
        end
    end

    // write stage trails the issue by the unit latency
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_en  <= 1'b0;
            wr_row <= '0;
            wr_col <= '0;
            wr_mat <= sa_pkg::mat_q;
        end else begin
            wr_en  <= issue;
            wr_row <= row;
            wr_col <= col;
            wr_mat <= mat_sel;
        end
    end

    // a new job must not start while the previous one is still issuing
    no_issue_in_load: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> !issue);

endmodule

// ==== verilog/sa_input_store.sv ====
// X and weight storage, filled from the load stream and read as projection operands
`timescale 1ns/1ps

module sa_input_store (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_valid,
    input  sa_pkg::phase_t  phase,
    input  sa_pkg::rows_t   rows,
    input  sa_pkg::idx_t    load_row,
    input  sa_pkg::idx_t    load_col,
    input  sa_pkg::elem_t   in_data,
    input  sa_pkg::elem_t   w_q,
    input  sa_pkg::elem_t   w_k,
    input  sa_pkg::elem_t   w_v,
    input  sa_pkg::idx_t    row,
    input  sa_pkg::idx_t    col,
    input  sa_pkg::mat_t    mat_sel,
    output sa_pkg::elem_t   x_vec [sa_pkg::dim],
    output sa_pkg::elem_t   w_vec [sa_pkg::dim]
);

    sa_pkg::elem_t x_mem [sa_pkg::dim][sa_pkg::dim];
    sa_pkg::elem_t w_mem [3][sa_pkg::dim][sa_pkg::dim];
    logic          x_wr;

    // X arrives alongside WQ, rows at or above T are dropped
    assign x_wr = in_valid && (mat_sel == sa_pkg::mat_q) && ({1'b0, load_row} < rows);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < sa_pkg::dim; r++) begin
                for (int c = 0; c < sa_pkg::dim; c++) begin
                    x_mem[r][c] <= '0;
                end
            end
        end else if (x_wr) begin
            x_mem[load_row][load_col] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            case (mat_sel)
                sa_pkg::mat_q: w_mem[0][load_row][load_col] <= w_q;
                sa_pkg::mat_k: w_mem[1][load_row][load_col] <= w_k;
                default:       w_mem[2][load_row][load_col] <= w_v;
            endcase
        end
    end

    // X row times one weight column, held at zero outside proj
    always_comb begin
        for (int i = 0; i < sa_pkg::dim; i++) begin
            if (phase == sa_pkg::ph_proj) begin
                x_vec[i] = x_mem[row][i];
                w_vec[i] = w_mem[mat_sel][i][col];
            end else begin
                x_vec[i] = '0;
                w_vec[i] = '0;
            end
        end
    end

endmodule

// ==== verilog/sa_qkv_store.sv ====
// Q, K and V matrices written from projection sums and read as wide-unit operands
`timescale 1ns/1ps

module sa_qkv_store (
    input  logic            clk,
    input  logic            rst_n,
    input  sa_pkg::phase_t  phase,
    input  logic            proj_valid,
    input  sa_pkg::proj_t   proj_sum,
    input  sa_pkg::idx_t    wr_row,
    input  sa_pkg::idx_t    wr_col,
    input  sa_pkg::mat_t    wr_mat,
    input  sa_pkg::idx_t    row,
    input  sa_pkg::idx_t    col,
    output sa_pkg::attn_t   q_vec [sa_pkg::dim],
    output sa_pkg::proj_t   kv_vec [sa_pkg::dim]
);

    sa_pkg::proj_t q_mem [sa_pkg::dim][sa_pkg::dim];
    sa_pkg::proj_t k_mem [sa_pkg::dim][sa_pkg::dim];
    sa_pkg::proj_t v_mem [sa_pkg::dim][sa_pkg::dim];
    logic          proj_d;

    // sums arrive one cycle after issue, so the last one lands in score
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            proj_d <= 1'b0;
            for (int r = 0; r < sa_pkg::dim; r++) begin
                for (int c = 0; c < sa_pkg::dim; c++) begin
                    q_mem[r][c] <= '0;
                    k_mem[r][c] <= '0;
                    v_mem[r][c] <= '0;
                end
            end
        end else begin
            proj_d <= (phase == sa_pkg::ph_proj);
            if (proj_valid && proj_d) begin
                case (wr_mat)
                    sa_pkg::mat_q: q_mem[wr_row][wr_col] <= proj_sum;
                    sa_pkg::mat_k: k_mem[wr_row][wr_col] <= proj_sum;
                    default:       v_mem[wr_row][wr_col] <= proj_sum;
                endcase
            end
        end
    end

    // score reads Q row by K row, out reads a V column
    always_comb begin
        for (int i = 0; i < sa_pkg::dim; i++) begin
            q_vec[i]  = '0;
            kv_vec[i] = '0;
            if (phase == sa_pkg::ph_score) begin
                q_vec[i]  = sa_pkg::attn_t'(q_mem[row][i]);
                kv_vec[i] = k_mem[col][i];
            end else if (phase == sa_pkg::ph_out) begin
                kv_vec[i] = v_mem[i][col];
            end
        end
    end

endmodule

// ==== verilog/sa_attention_store.sv ====
// score scaling and ReLU into the A matrix, A-row operands, and the registered result stream
`timescale 1ns/1ps

module sa_attention_store (
    input  logic            clk,
    input  logic            rst_n,
    input  sa_pkg::phase_t  phase,
    input  sa_pkg::rows_t   rows,
    input  logic            wide_valid,
    input  sa_pkg::wide_t   wide_sum,
    input  sa_pkg::idx_t    wr_row,
    input  sa_pkg::idx_t    wr_col,
    input  sa_pkg::idx_t    row,
    output sa_pkg::attn_t   a_vec [sa_pkg::dim],
    output logic            out_valid,
    output sa_pkg::out_t    out_data
);

    sa_pkg::attn_t  a_mem [sa_pkg::dim][sa_pkg::dim];
    sa_pkg::phase_t phase_d;
    sa_pkg::wide_t  quot;
    sa_pkg::attn_t  score_val;
    logic           score_start;
    logic           score_wr;
    logic           out_wr;

    // phase of the item whose sum is arriving now
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase_d <= sa_pkg::ph_idle;
        end else begin
            phase_d <= phase;
        end
    end

    assign score_start = (phase == sa_pkg::ph_score) && (phase_d != sa_pkg::ph_score);
    assign score_wr    = wide_valid && (phase_d == sa_pkg::ph_score);
    assign out_wr      = wide_valid && (phase_d == sa_pkg::ph_out);

    // signed divide truncates toward zero, then ReLU
    assign quot      = wide_sum / sa_pkg::wide_t'(3);
    assign score_val = (quot < 0) ? '0 : sa_pkg::attn_t'(quot);

    // clearing at score start keeps columns at or above T at zero
    always_ff @(posedge clk) begin
        if (score_start) begin
            for (int r = 0; r < sa_pkg::dim; r++) begin
                for (int c = 0; c < sa_pkg::dim; c++) begin
                    a_mem[r][c] <= '0;
                end
            end
        end else if (score_wr) begin
            a_mem[wr_row][wr_col] <= score_val;
        end
    end

    // with T = 1 the last score lands in the same cycle as the first A-row read
    always_comb begin
        for (int i = 0; i < sa_pkg::dim; i++) begin
            if (phase != sa_pkg::ph_out) begin
                a_vec[i] = '0;
            end else if (score_wr && wr_row == row && wr_col == 3'(i)) begin
                a_vec[i] = score_val;
            end else begin
                a_vec[i] = a_mem[row][i];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_data  <= '0;
        end else if (out_wr) begin
            out_valid <= 1'b1;
            out_data  <= sa_pkg::out_t'(wide_sum);
        end else begin
            out_valid <= 1'b0;
            out_data  <= '0;
        end
    end

    // score indices come from the sequencer's T x T walk
    score_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        score_wr |-> ({1'b0, wr_row} < rows) && ({1'b0, wr_col} < rows));

endmodule

// ==== verilog/sa_top.sv ====
// attention engine top level, connects the sequencer, operand stores and both dot-product units
`timescale 1ns/1ps

module sa_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  logic [3:0]        t_rows,
    input  sa_pkg::elem_t     in_data,
    input  sa_pkg::elem_t     w_q,
    input  sa_pkg::elem_t     w_k,
    input  sa_pkg::elem_t     w_v,
    output logic              out_valid,
    output sa_pkg::out_t      out_data
);

    sa_pkg::phase_t phase;
    sa_pkg::rows_t  rows;
    sa_pkg::idx_t   load_row;
    sa_pkg::idx_t   load_col;
    sa_pkg::idx_t   row;
    sa_pkg::idx_t   col;
    sa_pkg::mat_t   mat_sel;
    logic           issue;
    sa_pkg::idx_t   wr_row;
    sa_pkg::idx_t   wr_col;
    sa_pkg::mat_t   wr_mat;

    sa_pkg::elem_t  x_vec [sa_pkg::dim];
    sa_pkg::elem_t  w_vec [sa_pkg::dim];
    logic           proj_valid;
    sa_pkg::proj_t  proj_sum;

    sa_pkg::attn_t  q_vec [sa_pkg::dim];
    sa_pkg::proj_t  kv_vec [sa_pkg::dim];
    sa_pkg::attn_t  a_vec [sa_pkg::dim];
    sa_pkg::attn_t  wide_a [sa_pkg::dim];
    logic           wide_valid;
    sa_pkg::wide_t  wide_sum;

    // Q row feeds the wide unit during score, A row during out
    always_comb begin
        for (int i = 0; i < sa_pkg::dim; i++) begin
            wide_a[i] = (phase == sa_pkg::ph_score) ? q_vec[i] : a_vec[i];
        end
    end

    sa_sequencer sa_sequencer_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .t_rows   (t_rows),
        .phase    (phase),
        .rows     (rows),
        .load_row (load_row),
        .load_col (load_col),
        .row      (row),
        .col      (col),
        .mat_sel  (mat_sel),
        .issue    (issue),
        .wr_en    (),
        .wr_row   (wr_row),
        .wr_col   (wr_col),
        .wr_mat   (wr_mat)
    );

    sa_input_store sa_input_store_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .phase    (phase),
        .rows     (rows),
        .load_row (load_row),
        .load_col (load_col),
        .in_data  (in_data),
        .w_q      (w_q),
        .w_k      (w_k),
        .w_v      (w_v),
        .row      (row),
        .col      (col),
        .mat_sel  (mat_sel),
        .x_vec    (x_vec),
        .w_vec    (w_vec)
    );

    sa_dot_product #(
        .a_t   (sa_pkg::elem_t),
        .b_t   (sa_pkg::elem_t),
        .sum_t (sa_pkg::proj_t)
    ) proj_dot (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_strobe  (issue),
        .a_vec      (x_vec),
        .b_vec      (w_vec),
        .out_strobe (proj_valid),
        .sum        (proj_sum)
    );

    sa_qkv_store sa_qkv_store_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .phase      (phase),
        .proj_valid (proj_valid),
        .proj_sum   (proj_sum),
        .wr_row     (wr_row),
        .wr_col     (wr_col),
        .wr_mat     (wr_mat),
        .row        (row),
        .col        (col),
        .q_vec      (q_vec),
        .kv_vec     (kv_vec)
    );

    sa_dot_product #(
        .a_t   (sa_pkg::attn_t),
        .b_t   (sa_pkg::proj_t),
        .sum_t (sa_pkg::wide_t)
    ) wide_dot (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_strobe  (issue),
        .a_vec      (wide_a),
        .b_vec      (kv_vec),
        .out_strobe (wide_valid),
        .sum        (wide_sum)
    );

    sa_attention_store sa_attention_store_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .phase      (phase),
        .rows       (rows),
        .wide_valid (wide_valid),
        .wide_sum   (wide_sum),
        .wr_row     (wr_row),
        .wr_col     (wr_col),
        .row        (row),
        .a_vec      (a_vec),
        .out_valid  (out_valid),
        .out_data   (out_data)
    );

endmodule

// ==== test/sa_model.svh ====
// reference model of the attention engine, included inside the testbench module and run once per job
`ifndef SA_MODEL_SVH
`define SA_MODEL_SVH

    // model matrices of the current job, entry [row][col]
    longint q_ref [8][8];
    longint k_ref [8][8];
    longint v_ref [8][8];
    longint a_ref [8][8];

    // signed divide by 3, rounded toward zero
    function automatic longint div3_trunc(input longint s);
        if (s < 0) begin
            return -((-s) / 3);
        end
        return s / 3;
    endfunction

    // fills exp_out with the 8T row-major results, counts negative raw scores
    task automatic compute_expected(input int t, output int neg_count);
        longint s;
        longint quo;
        longint acc;
        neg_count = 0;
        for (int i = 0; i < t; i++) begin
            for (int c = 0; c < 8; c++) begin
                q_ref[i][c] = 0;
                k_ref[i][c] = 0;
                v_ref[i][c] = 0;
                for (int j = 0; j < 8; j++) begin
                    q_ref[i][c] += longint'(x_m[i][j]) * longint'(wq_m[j][c]);
                    k_ref[i][c] += longint'(x_m[i][j]) * longint'(wk_m[j][c]);
                    v_ref[i][c] += longint'(x_m[i][j]) * longint'(wv_m[j][c]);
                end
            end
        end
        // only the T x T block of A exists
        for (int i = 0; i < t; i++) begin
            for (int j = 0; j < t; j++) begin
                s = 0;
                for (int c = 0; c < 8; c++) begin
                    s += q_ref[i][c] * k_ref[j][c];
                end
                if (s < 0) begin
                    neg_count++;
                end
                quo = div3_trunc(s);
                a_ref[i][j] = (quo < 0) ? 0 : quo;
            end
        end
        for (int i = 0; i < t; i++) begin
            for (int c = 0; c < 8; c++) begin
                acc = 0;
                for (int j = 0; j < t; j++) begin
                    acc += a_ref[i][j] * v_ref[j][c];
                end
                exp_out[i * 8 + c] = acc;
            end
        end
    endtask

`endif

// ==== test/tb_sa.sv ====
// testbench for the attention engine, runs random jobs of each row count against a reference model
`timescale 1ns/1ps

module tb_sa;

    localparam int half_period = 2;
    localparam int num_jobs    = 8;
    // worst-case job length plus margin
    localparam int job_cycles  = 192 + 24 * 8 + 64 + 8 * 8 + 50;

    logic          clk = 1'b0;
    logic          rst_n;
    logic          in_valid;
    logic [3:0]    t_rows;
    sa_pkg::elem_t in_data;
    sa_pkg::elem_t w_q;
    sa_pkg::elem_t w_k;
    sa_pkg::elem_t w_v;
    logic          out_valid;
    sa_pkg::out_t  out_data;

    integer seed        = 32'h2a6eb1bf;
    int     error_count = 0;
    int     check_count = 0;

    // stimulus of the current job, entry [row][col]
    byte    x_m  [8][8];
    byte    wq_m [8][8];
    byte    wk_m [8][8];
    byte    wv_m [8][8];
    longint exp_out [64];

    `include "sa_model.svh"

    sa_top sa_top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .t_rows    (t_rows),
        .in_data   (in_data),
        .w_q       (w_q),
        .w_k       (w_k),
        .w_v       (w_v),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    always #half_period clk = ~clk;

    function automatic byte rand_elem();
        return byte'($random(seed));
    endfunction

    // t_rows encoding, anything but 1 or 4 means eight rows
    function automatic int rows_for(input logic [3:0] sel);
        case (sel)
            4'd1:    return 1;
            4'd4:    return 4;
            default: return 8;
        endcase
    endfunction

    task automatic make_stimulus(input bit neg_mode);
        for (int r = 0; r < 8; r++) begin
            for (int c = 0; c < 8; c++) begin
                x_m[r][c]  = rand_elem();
                wq_m[r][c] = rand_elem();
                wv_m[r][c] = rand_elem();
                // WK = -WQ gives K = -Q, so diagonal scores go negative
                if (neg_mode) begin
                    if (wq_m[r][c] == byte'(-128)) begin
                        wq_m[r][c] = byte'(-127);
                    end
                    wk_m[r][c] = -wq_m[r][c];
                end else begin
                    wk_m[r][c] = rand_elem();
                end
            end
        end
    endtask

    task automatic drive_idle();
        in_valid = 1'b0;
        t_rows   = 4'd0;
        in_data  = '0;
        w_q      = '0;
        w_k      = '0;
        w_v      = '0;
    endtask

    task automatic check_quiet(input string where, input int job);
        if (out_valid !== 1'b0) begin
            $display("mismatch out_valid during %s of job %0d: expected %h, got %h",
                     where, job, 1'b0, out_valid);
            error_count++;
        end
        if (out_data !== '0) begin
            $display("mismatch out_data during %s of job %0d: expected %h, got %h",
                     where, job, 64'h0, out_data);
            error_count++;
        end
    endtask

    task automatic run_job(input int job, input logic [3:0] sel, input bit neg_mode);
        int t;
        int neg_count;
        int wait_cnt;
        int latency;
        t = rows_for(sel);
        make_stimulus(neg_mode);
        compute_expected(t, neg_count);
        if (neg_mode && neg_count == 0) begin
            $display("job %0d: stimulus produced no negative scores", job);
            error_count++;
        end
        // unused slots carry random values that the DUT must ignore
        for (int k = 0; k < sa_pkg::load_cycles; k++) begin
            @(negedge clk);
            check_quiet("load", job);
            in_valid = 1'b1;
            t_rows   = (k == 0) ? sel : 4'($random(seed));
            in_data  = (k < 8 * t) ? x_m[k / 8][k % 8] : rand_elem();
            w_q      = (k < 64) ? wq_m[k / 8][k % 8] : rand_elem();
            w_k      = (k >= 64 && k < 128) ? wk_m[(k % 64) / 8][k % 8] : rand_elem();
            w_v      = (k >= 128) ? wv_m[(k % 64) / 8][k % 8] : rand_elem();
        end
        wait_cnt = 0;
        do begin
            @(negedge clk);
            drive_idle();
            wait_cnt++;
        end while (!out_valid && wait_cnt < job_cycles);
        if (!out_valid) begin
            $display("job %0d: out_valid did not rise within %0d cycles", job, job_cycles);
            error_count++;
            return;
        end
        latency = 24 * t + t * t + 3;
        if (wait_cnt != latency) begin
            $display("job %0d: first out_valid came %0d cycles after load, expected %0d",
                     job, wait_cnt, latency);
            error_count++;
        end
        for (int n = 0; n < 8 * t; n++) begin
            if (n > 0) begin
                @(negedge clk);
            end
            if (!out_valid) begin
                $display("job %0d: out_valid dropped after %0d of %0d outputs", job, n, 8 * t);
                error_count++;
                return;
            end
            if (out_data !== sa_pkg::out_t'(exp_out[n])) begin
                $display("mismatch out_data job %0d index %0d: expected %h, got %h",
                         job, n, exp_out[n], out_data);
                error_count++;
            end
            check_count++;
        end
        @(negedge clk);
        if (out_valid) begin
            $display("job %0d: out_valid stayed high past %0d outputs", job, 8 * t);
            error_count++;
        end
    endtask

    initial begin
        rst_n = 1'b0;
        drive_idle();
        for (int i = 0; i < 16; i++) begin
            @(negedge clk);
            check_quiet("reset", 0);
        end
        rst_n = 1'b1;
        run_job(1, 4'd8, 1'b0);
        run_job(2, 4'd1, 1'b0);
        run_job(3, 4'd4, 1'b0);
        run_job(4, 4'd8, 1'b1);
        run_job(5, 4'd4, 1'b1);
        // out-of-range selector falls back to eight rows
        run_job(6, 4'd0, 1'b0);
        run_job(7, 4'd1, 1'b1);
        run_job(8, 4'd4, 1'b0);
        $display("summary: %0d errors over %0d checked outputs", error_count, check_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(num_jobs * job_cycles * 2 * half_period);
        error_count++;
        $display("watchdog: run exceeded %0d cycles", num_jobs * job_cycles);
        $display("summary: %0d errors over %0d checked outputs", error_count, check_count);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+test
common/sa_pkg.sv
verilog/sa_dot_product.sv
verilog/sa_sequencer.sv
verilog/sa_input_store.sv
verilog/sa_qkv_store.sv
verilog/sa_attention_store.sv
verilog/sa_top.sv
test/tb_sa.sv

// ==== Makefile ====
TOOL       = verilator
FILELIST   = tb.f
TOP        = tb_sa
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "NO ERRORS" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
